// File: rtl/addrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "socCfg.svh"

module addrDecoder (
  input  wire logic            hclk_i,
  input  wire logic            arstN_i,

  input  wire socPkg::ahbReq_t req_i,

  // Slave answers
  input  wire socPkg::ahbRsp_t ramRsp_i,
  input  wire socPkg::ahbRsp_t timerRsp_i,
  input  wire socPkg::ahbRsp_t errRsp_i,

  // Per-slave select
  output logic                 ramSel_o,
  output logic                 timerSel_o,
  output logic                 errSel_o,

  output logic                 hready_o,
  output socPkg::ahbRsp_t      rsp_o
);

  import socPkg::*;

  ////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////

  logic      ramHit;
  logic      timerHit;
  slaveSel_t addrSel;
  slaveSel_t dataSelQ;

  assign ramHit   = (req_i.addr & `SOC_RAM_MASK) == `SOC_RAM_BASE;
  assign timerHit = (req_i.addr & `SOC_TIMER_MASK) == `SOC_TIMER_BASE;

  // RAM wins if the regions ever overlap
  always_comb begin
    if (ramHit) begin
      addrSel = SEL_RAM;
    end else if (timerHit) begin
      addrSel = SEL_TIMER;
    end else begin
      addrSel = SEL_ERROR;
    end
  end

  assign ramSel_o   = req_i.sel && (addrSel == SEL_RAM);
  assign timerSel_o = req_i.sel && (addrSel == SEL_TIMER);
  assign errSel_o   = req_i.sel && (addrSel == SEL_ERROR);

  ////////////////////////////////////////
  // Data phase select and response mux
  ////////////////////////////////////////

  // Moves on only when the current data phase completes
  always_ff @(posedge hclk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      dataSelQ <= SEL_RAM;
    end else if (hready_o) begin
      dataSelQ <= addrSel;
    end
  end

  always_comb begin
    case (dataSelQ)
      SEL_RAM:   rsp_o = ramRsp_i;
      SEL_TIMER: rsp_o = timerRsp_i;
      default:   rsp_o = errRsp_i;
    endcase
  end

  // HREADY back to the master and to all slaves
  assign hready_o = rsp_o.readyOut;

endmodule

`default_nettype wire

// File: rtl/errorSlave.sv
`timescale 1ns/1ps
`default_nettype none

module errorSlave (
  input  wire logic            hclk_i,
  input  wire logic            arstN_i,

  input  wire socPkg::ahbReq_t req_i,
  input  wire logic            sel_i,
  input  wire logic            hready_i,
  output socPkg::ahbRsp_t      rsp_o
);

  import socPkg::*;

  typedef enum logic [1:0] {
    IDLE_ST,
    ERR1_ST,
    ERR2_ST
  } errState_t;

  errState_t stateQ;
  errState_t stateD;
  logic      accept;

  assign accept = sel_i && hready_i && (req_i.trans == NONSEQ);

  // Two-cycle ERROR response
  always_comb begin
    stateD = stateQ;
    case (stateQ)
      IDLE_ST: stateD = accept ? ERR1_ST : IDLE_ST;
      ERR1_ST: stateD = ERR2_ST;
      ERR2_ST: stateD = accept ? ERR1_ST : IDLE_ST;
      default: stateD = IDLE_ST;
    endcase
  end

  always_ff @(posedge hclk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      stateQ <= IDLE_ST;
    end else begin
      stateQ <= stateD;
    end
  end

  // First cycle stalls, second completes
  assign rsp_o.rdata    = '0;
  assign rsp_o.readyOut = (stateQ != ERR1_ST);
  assign rsp_o.resp     = (stateQ == IDLE_ST) ? OKAY : ERROR;

endmodule

`default_nettype wire

// File: rtl/ramSlave.sv
`timescale 1ns/1ps
`default_nettype none

`include "socCfg.svh"

module ramSlave #(
  parameter int memWords = `SOC_RAM_WORDS
) (
  input  wire logic            hclk_i,
  input  wire logic            arstN_i,

  input  wire socPkg::ahbReq_t req_i,
  input  wire logic            sel_i,
  input  wire logic            hready_i,
  output socPkg::ahbRsp_t      rsp_o
);

  import socPkg::*;

  localparam int IdxW = $clog2(memWords);

  logic [`SOC_DATA_W-1:0] mem [memWords];

  logic            accept;
  logic [IdxW-1:0] idxQ;
  logic            wrPendQ;

  assign accept = sel_i && hready_i && (req_i.trans == NONSEQ);

  ////////////////////////////////////////
  // Address phase capture
  ////////////////////////////////////////

  always_ff @(posedge hclk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      wrPendQ <= 1'b0;
    end else if (hready_i) begin
      wrPendQ <= accept && req_i.write;
    end
  end

  // Word index, byte lanes dropped
  always_ff @(posedge hclk_i) begin
    if (accept) begin
      idxQ <= req_i.addr[IdxW+1:2];
    end
  end

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////

  // Write lands at the end of the data phase
  always_ff @(posedge hclk_i) begin
    if (wrPendQ && hready_i) begin
      mem[idxQ] <= req_i.wdata;
    end
  end

  // Zero wait states, never errors
  assign rsp_o.rdata    = mem[idxQ];
  assign rsp_o.readyOut = 1'b1;
  assign rsp_o.resp     = OKAY;

endmodule

`default_nettype wire

// File: rtl/socBusTop.sv
`timescale 1ns/1ps
`default_nettype none

module socBusTop (
  input  wire logic            hclk_i,
  input  wire logic            arstN_i,

  // Master port
  input  wire socPkg::ahbReq_t req_i,
  output socPkg::ahbRsp_t      rsp_o,

  // Timer interrupt
  output logic                 tint_o
);

  import socPkg::*;

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  logic    ramSel;
  logic    timerSel;
  logic    errSel;
  logic    hready;

  ahbRsp_t ramRsp;
  ahbRsp_t timerRsp;
  ahbRsp_t errRsp;

  addrDecoder uDecoder (
    .hclk_i    (hclk_i),
    .arstN_i   (arstN_i),
    .req_i     (req_i),
    .ramRsp_i  (ramRsp),
    .timerRsp_i(timerRsp),
    .errRsp_i  (errRsp),
    .ramSel_o  (ramSel),
    .timerSel_o(timerSel),
    .errSel_o  (errSel),
    .hready_o  (hready),
    .rsp_o     (rsp_o)
  );

  ////////////////////////////////////////
  // Slaves
  ////////////////////////////////////////

  // On-chip RAM
  ramSlave uRam (
    .hclk_i  (hclk_i),
    .arstN_i (arstN_i),
    .req_i   (req_i),
    .sel_i   (ramSel),
    .hready_i(hready),
    .rsp_o   (ramRsp)
  );

  timerSlave uTimer (
    .hclk_i  (hclk_i),
    .arstN_i (arstN_i),
    .req_i   (req_i),
    .sel_i   (timerSel),
    .hready_i(hready),
    .rsp_o   (timerRsp),
    .tint_o  (tint_o)
  );

  // Catches everything outside the map
  errorSlave uError (
    .hclk_i  (hclk_i),
    .arstN_i (arstN_i),
    .req_i   (req_i),
    .sel_i   (errSel),
    .hready_i(hready),
    .rsp_o   (errRsp)
  );

endmodule

`default_nettype wire

// File: rtl/socCfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

`define SOC_ADDR_W 32
`define SOC_DATA_W 32

////////////////////////////////////////
// Memory map
////////////////////////////////////////

// RAM window of 64kB, only the first 4kB are backed
`define SOC_RAM_BASE   32'h0011_0000
`define SOC_RAM_MASK   32'hFFFF_0000

// Timer window of 4kB
`define SOC_TIMER_BASE 32'h0020_0000
`define SOC_TIMER_MASK 32'hFFFF_F000

// RAM depth in words
`define SOC_RAM_WORDS  1024

`endif

// File: rtl/socPkg.sv
`default_nettype none

`include "socCfg.svh"

package socPkg;

  // AHB transfer type encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // HRESP
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } respKind_t;

  // Master side, address and data phase signals
  typedef struct packed {
    logic                   sel;
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   write;
    htrans_t                trans;
    logic [`SOC_DATA_W-1:0] wdata;
  } ahbReq_t;

  // Slave answer
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   readyOut;
    respKind_t              resp;
  } ahbRsp_t;

  // Which slave owns the current data phase
  typedef enum logic [1:0] {
    SEL_RAM   = 2'd0,
    SEL_TIMER = 2'd1,
    SEL_ERROR = 2'd2
  } slaveSel_t;

endpackage

`default_nettype wire

// File: rtl/timerSlave.sv
`timescale 1ns/1ps
`default_nettype none

`include "socCfg.svh"

module timerSlave (
  input  wire logic            hclk_i,
  input  wire logic            arstN_i,

  input  wire socPkg::ahbReq_t req_i,
  input  wire logic            sel_i,
  input  wire logic            hready_i,
  output socPkg::ahbRsp_t      rsp_o,

  output logic                 tint_o
);

  import socPkg::*;

  // Register codes derived from the byte offset
  localparam logic [1:0] RegCount   = 2'd0;
  localparam logic [1:0] RegCompare = 2'd1;
  localparam logic [1:0] RegControl = 2'd2;
  localparam logic [1:0] RegNone    = 2'd3;

  logic                   accept;
  logic [1:0]             addrReg;
  logic [1:0]             regQ;
  logic                   wrPendQ;
  logic                   wrEn;

  logic [`SOC_DATA_W-1:0] countQ;
  logic [`SOC_DATA_W-1:0] compareQ;
  logic [`SOC_DATA_W-1:0] controlQ;
  logic                   tintQ;

  assign accept = sel_i && hready_i && (req_i.trans == NONSEQ);

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // Offset inside the 4kB window
  always_comb begin
    case (req_i.addr[11:0])
      12'h000: addrReg = RegCount;
      12'h004: addrReg = RegCompare;
      12'h008: addrReg = RegControl;
      default: addrReg = RegNone;
    endcase
  end

  always_ff @(posedge hclk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      wrPendQ <= 1'b0;
      regQ    <= RegNone;
    end else if (hready_i) begin
      wrPendQ <= accept && req_i.write;
      regQ    <= accept ? addrReg : RegNone;
    end
  end

  assign wrEn = wrPendQ && hready_i;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge hclk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      countQ   <= '0;
      compareQ <= '0;
      controlQ <= '0;
    end else begin
      // A bus write to count overrides the increment
      if (wrEn && (regQ == RegCount)) begin
        countQ <= req_i.wdata;
      end else if (controlQ[0]) begin
        countQ <= countQ + `SOC_DATA_W'(1);
      end
      if (wrEn && (regQ == RegCompare)) begin
        compareQ <= req_i.wdata;
      end
      if (wrEn && (regQ == RegControl)) begin
        controlQ <= req_i.wdata;
      end
    end
  end

  // Interrupt lags its condition by one clock
  always_ff @(posedge hclk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      tintQ <= 1'b0;
    end else begin
      tintQ <= controlQ[0] && (countQ >= compareQ);
    end
  end

  assign tint_o = tintQ;

  ////////////////////////////////////////
  // Read back
  ////////////////////////////////////////

  always_comb begin
    case (regQ)
      RegCount:   rsp_o.rdata = countQ;
      RegCompare: rsp_o.rdata = compareQ;
      RegControl: rsp_o.rdata = controlQ;
      default:    rsp_o.rdata = '0;
    endcase
  end

  assign rsp_o.readyOut = 1'b1;
  assign rsp_o.resp     = OKAY;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tbSocBus -f sources.f -o simv \
  > build.log 2>&1 &&
  ./obj_dir/simv > sim.log 2>&1 ||
  echo "Build or simulation returned an error, see build.log and sim.log"

grep -q "^Simulation passed$" sim.log 2>/dev/null && echo "PASS" && exit 0 ||
  { echo "FAIL"; exit 1; }

// File: sources.f
+incdir+rtl
rtl/socPkg.sv
rtl/addrDecoder.sv
rtl/ramSlave.sv
rtl/timerSlave.sv
rtl/errorSlave.sv
rtl/socBusTop.sv
verif/clkGen.sv
verif/tbSocBus.sv

// File: verif/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
  parameter int periodNs    = 20,
  parameter int resetCycles = 2
) (
  output logic clk_o,
  output logic arstN_o
);

  initial begin
    clk_o   = 1'b0;
    arstN_o = 1'b0;
    forever #(periodNs / 2) clk_o = ~clk_o;
  end

  // Release on a rising edge
  initial begin
    repeat (resetCycles) @(posedge clk_o);
    arstN_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/tbSocBus.sv
`timescale 1ns/1ps
`default_nettype none

`include "socCfg.svh"

module tbSocBus;

  import socPkg::*;

  localparam logic [31:0] Seed          = 32'hb12cdb6a;
  localparam int          NumRamOps     = 200;
  localparam int          NumErrOps     = 8;
  localparam int          ResetLimit    = 10;
  localparam int          StallLimit    = 16;
  localparam int          TintRiseLimit = 200;
  localparam int          TintFallLimit = 2;

  // Transfer whose data phase is still open
  typedef struct packed {
    logic        valid;
    logic        chkData;
    logic [31:0] expData;
    logic [31:0] wdata;
    respKind_t   expResp;
    logic [1:0]  expWaits;
  } pending_t;

  logic        hclk;
  logic        arstN;
  ahbReq_t     req;
  ahbRsp_t     rsp;
  logic        tint;

  pending_t    pend;
  string       pendName;
  logic [31:0] lastRdata;
  logic [31:0] rngState;
  int          checks;
  int          errors;
  int          timeouts;

  // Reference model
  logic [31:0] ramModel [int];
  int          writtenIdx [$];
  logic [31:0] timerCompare;
  logic [31:0] timerControl;

  clkGen #(
    .periodNs   (20),
    .resetCycles(2)
  ) uClk (
    .clk_o  (hclk),
    .arstN_o(arstN)
  );

  socBusTop DUT (
    .hclk_i (hclk),
    .arstN_i(arstN),
    .req_i  (req),
    .rsp_o  (rsp),
    .tint_o (tint)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  function automatic logic [31:0] ramAddr(input int idx);
    return `SOC_RAM_BASE + (32'(idx) << 2);
  endfunction

  // Any word index the model has seen written
  function automatic int pickWritten();
    return writtenIdx[nextRand() % writtenIdx.size()];
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    errors++;
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout: %s", what);
    errors++;
    timeouts++;
  endtask

  ////////////////////////////////////////
  // Master
  ////////////////////////////////////////

  // Entered just after a rising edge and returns on the edge that accepts the address
  task automatic busStep(input logic active, input string name, input logic [31:0] addr,
                         input logic write, input logic [31:0] wdata, input logic chkData,
                         input logic [31:0] expData, input respKind_t expResp,
                         input logic [1:0] expWaits);
    int   waits;
    logic done;
    waits = 0;
    done  = 1'b0;
    req.sel   <= active;
    req.addr  <= addr;
    req.write <= write;
    req.trans <= active ? NONSEQ : IDLE;
    // Write data of the transfer now in its data phase
    req.wdata <= pend.wdata;
    while (!done) begin
      @(negedge hclk);
      if (rsp.readyOut === 1'b1) begin
        done = 1'b1;
      end else begin
        waits++;
        assert (pend.valid)
          else begin
            $display("readyOut went low with no transfer in its data phase");
            errors++;
          end
        if (pend.valid) begin
          assert (rsp.resp === pend.expResp)
            else reportMismatch({pendName, " stall resp"}, 32'(pend.expResp), 32'(rsp.resp));
        end
        if (waits > StallLimit) begin
          reportTimeout({pendName, " kept readyOut low"});
          done = 1'b1;
        end else begin
          @(posedge hclk);
        end
      end
    end
    if (pend.valid && rsp.readyOut === 1'b1) begin
      checks++;
      assert (waits == int'(pend.expWaits))
        else reportMismatch({pendName, " wait states"}, 32'(pend.expWaits), 32'(waits));
      assert (rsp.resp === pend.expResp)
        else reportMismatch({pendName, " resp"}, 32'(pend.expResp), 32'(rsp.resp));
      if (pend.chkData) begin
        assert (rsp.rdata === pend.expData)
          else reportMismatch({pendName, " rdata"}, pend.expData, rsp.rdata);
      end
      lastRdata = rsp.rdata;
    end
    pend.valid    = active;
    pend.chkData  = chkData;
    pend.expData  = expData;
    pend.wdata    = wdata;
    pend.expResp  = expResp;
    pend.expWaits = expWaits;
    pendName      = name;
    @(posedge hclk);
  endtask

  task automatic writeWord(input string name, input logic [31:0] addr, input logic [31:0] data);
    busStep(1'b1, name, addr, 1'b1, data, 1'b0, '0, OKAY, 2'd0);
  endtask

  task automatic readWord(input string name, input logic [31:0] addr, input logic chk,
                          input logic [31:0] exp);
    busStep(1'b1, name, addr, 1'b0, '0, chk, exp, OKAY, 2'd0);
  endtask

  // Closes the open data phase
  task automatic idleCycle();
    busStep(1'b0, "idle", '0, 1'b0, '0, 1'b0, '0, OKAY, 2'd0);
  endtask

  task automatic waitForTint(input logic level, input int limit, input string what);
    int n;
    n = 1;
    @(negedge hclk);
    while (tint !== level && n < limit) begin
      @(negedge hclk);
      n++;
    end
    checks++;
    if (tint !== level) begin
      reportTimeout(what);
    end
    @(posedge hclk);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic resetAndCheck();
    int n;
    n = 0;
    @(negedge hclk);
    while (arstN !== 1'b1 && n < ResetLimit) begin
      @(negedge hclk);
      n++;
    end
    if (arstN !== 1'b1) begin
      reportTimeout("reset was never released");
    end
    checks++;
    assert (rsp.readyOut === 1'b1) else reportMismatch("reset readyOut", 32'h1, 32'(rsp.readyOut));
    assert (rsp.resp === OKAY) else reportMismatch("reset resp", 32'(OKAY), 32'(rsp.resp));
    assert (tint === 1'b0) else reportMismatch("reset tint_o", 32'h0, 32'(tint));
    @(posedge hclk);
  endtask

  task automatic ramRandomTest();
    int          i;
    int          idx;
    logic [31:0] coin;
    logic [31:0] data;
    for (i = 0; i < NumRamOps; i++) begin
      coin = nextRand();
      if (writtenIdx.size() == 0 || coin[0]) begin
        idx  = int'(nextRand() % `SOC_RAM_WORDS);
        data = nextRand();
        if (!ramModel.exists(idx)) begin
          writtenIdx.push_back(idx);
        end
        ramModel[idx] = data;
        writeWord("ram write", ramAddr(idx), data);
      end else begin
        idx = pickWritten();
        readWord("ram read", ramAddr(idx), 1'b1, ramModel[idx]);
      end
    end
    idleCycle();
  endtask

  task automatic unmappedTest();
    int          i;
    int          idx;
    logic [31:0] addr;
    logic [31:0] coin;
    for (i = 0; i < NumErrOps; i++) begin
      // Bit 31 set lies outside both regions
      addr = nextRand() | 32'h8000_0000;
      coin = nextRand();
      busStep(1'b1, "unmapped", addr, coin[0], nextRand(), 1'b1, '0, ERROR, 2'd1);
      idx = pickWritten();
      readWord("ram after error", ramAddr(idx), 1'b1, ramModel[idx]);
    end
    idleCycle();
  endtask

  task automatic timerTest();
    logic [31:0] firstCount;
    timerCompare = nextRand() % 64;
    writeWord("timer count write", `SOC_TIMER_BASE, '0);
    writeWord("timer compare write", `SOC_TIMER_BASE + 32'h4, timerCompare);
    readWord("timer compare read", `SOC_TIMER_BASE + 32'h4, 1'b1, timerCompare);
    timerControl = 32'h1;
    writeWord("timer enable", `SOC_TIMER_BASE + 32'h8, timerControl);
    idleCycle();
    waitForTint(1'b1, TintRiseLimit, "tint_o did not rise after enable");
    readWord("timer count read", `SOC_TIMER_BASE, 1'b0, '0);
    idleCycle();
    checks++;
    assert (lastRdata >= timerCompare)
      else reportMismatch("timer count at least compare", timerCompare, lastRdata);

    // Disabled so the count freezes
    timerControl = 32'h0;
    writeWord("timer disable", `SOC_TIMER_BASE + 32'h8, timerControl);
    idleCycle();
    waitForTint(1'b0, TintFallLimit, "tint_o still high two cycles after disable");
    readWord("timer count read", `SOC_TIMER_BASE, 1'b0, '0);
    idleCycle();
    firstCount = lastRdata;
    readWord("timer count read", `SOC_TIMER_BASE, 1'b0, '0);
    idleCycle();
    checks++;
    assert (lastRdata === firstCount)
      else reportMismatch("timer count frozen", firstCount, lastRdata);
    readWord("timer control read", `SOC_TIMER_BASE + 32'h8, 1'b1, timerControl);
    idleCycle();
  endtask

  initial begin
    req          <= '0;
    pend         = '0;
    pendName     = "none";
    lastRdata    = '0;
    rngState     = Seed;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    timerCompare = '0;
    timerControl = '0;
    resetAndCheck();
    ramRandomTest();
    unmappedTest();
    timerTest();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
